//--- hw/bank_translate.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_macros.svh"

module bank_translate (
	input  map_bus_pkg::cpu_bus_t  cpu,
	input  map_bus_pkg::ppu_bus_t  ppu,
	input  logic                   m2,
	input  logic                   cfg_chr_ram,
	input  map_reg_pkg::map_regs_t regs,
	output map_bus_pkg::mem_out_t  mem
);

	localparam logic [`MAP_PRG_BW-1:0] prg_last = '1;
	localparam logic [`MAP_PRG_BW-1:0] prg_penult = prg_last - 1'b1;

	logic [`MAP_PRG_BW-1:0] prg_sel;
	logic [`MAP_PRG_BW-1:0] prg_bank;
	logic [`MAP_CHR_BW-1:0] chr_sel;
	logic [`MAP_CHR_BW-1:0] chr_bank;
	logic                   a12_eff;
	logic                   ram_win;

	// board 37 outer folding of an 8k prg bank
	function automatic logic [`MAP_PRG_BW-1:0] fold_prg(
		input logic [`MAP_PRG_BW-1:0] bank,
		input logic [2:0]             outer
	);
		if (outer <= 3'd2)
			fold_prg = {3'b000, bank[2:0]};
		else if (outer == 3'd3)
			fold_prg = {3'b001, bank[2:0]};
		else if (outer == 3'd7)
			fold_prg = {3'b100, bank[2:0]};
		else
			fold_prg = {2'b01, bank[3:0]}; // 128k half for 4..6
	endfunction

	always_comb begin
		case ({regs.prg_mode, cpu.addr[14:13]})
			3'b000, 3'b110: prg_sel = regs.prg[0];
			3'b001, 3'b101: prg_sel = regs.prg[1];
			3'b010, 3'b100: prg_sel = prg_penult; // swaps with r6 by mode
			default: prg_sel = prg_last;
		endcase
	end

	assign prg_bank = cpu.romsel ? '0 : fold_prg(prg_sel, regs.outer);

	// chr_a12 swaps the 2k and 1k halves
	assign a12_eff = ppu.addr[12] ^ regs.chr_a12;

	always_comb begin
		if (!a12_eff)
			chr_sel = {regs.chr[ppu.addr[11]][`MAP_CHR_BW-1:1], ppu.addr[10]};
		else
			chr_sel = regs.chr[3'd2 + {1'b0, ppu.addr[11:10]}];
	end

	assign chr_bank = regs.outer[2] ? {1'b1, chr_sel[`MAP_CHR_BW-2:0]} : chr_sel;

	assign ram_win = cpu.romsel && cpu.addr[14:13] == 2'b11;

	always_comb begin
		mem.prg_addr = {prg_bank, cpu.addr[`MAP_PRG_WIN-1:0]};
		mem.prg_ce = !cpu.romsel;
		mem.prg_oe = cpu.rw;
		mem.ram_ce = regs.ram_protect[1] && ram_win && m2;
		mem.ram_we = (mem.ram_ce && !cpu.rw) || regs.ram_protect[0];
		mem.sram_addr = cpu.addr[`MAP_SRAM_AW-1:0];
		mem.chr_addr = {chr_bank, ppu.addr[`MAP_CHR_WIN-1:0]};
		mem.ciram_ce = !ppu.addr[13];
		mem.chr_ce = mem.ciram_ce;
		mem.chr_oe = !ppu.oe;
		mem.chr_we = cfg_chr_ram && !ppu.we && !ppu.addr[13]; // chr ram boards only
		mem.ciram_a10 = regs.mirror ? ppu.addr[11] : ppu.addr[10];
	end

endmodule

`default_nettype wire

//--- hw/cpu_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_reg_decode (
	input  logic                  m2,
	input  logic                  map_rst,
	input  map_bus_pkg::cpu_bus_t cpu,
	output map_reg_pkg::reg_wr_t  wr
);

	logic [8:0] strobes;

	always_comb begin
		wr = '0;
		wr.data = cpu.data;
		if (!cpu.rw && !cpu.romsel) begin
			// a14, a13 and a0 pick the register
			case ({cpu.addr[14:13], cpu.addr[0]})
				3'd0: wr.bank_sel_wr = 1'b1;
				3'd1: wr.bank_data_wr = 1'b1;
				3'd2: wr.mirror_wr = 1'b1;
				3'd3: wr.protect_wr = 1'b1;
				3'd4: wr.latch_wr = 1'b1;
				3'd5: wr.reload_wr = 1'b1;
				3'd6: wr.irq_off_wr = 1'b1;
				3'd7: wr.irq_on_wr = 1'b1;
			endcase
		end
		if (!cpu.rw && cpu.romsel && cpu.addr[14:13] == 2'b11)
			wr.outer_wr = 1'b1; // shares the wram window
	end

	assign strobes = {
		wr.bank_sel_wr,
		wr.bank_data_wr,
		wr.mirror_wr,
		wr.protect_wr,
		wr.latch_wr,
		wr.reload_wr,
		wr.irq_off_wr,
		wr.irq_on_wr,
		wr.outer_wr
	};

	a_one_strobe: assert property (
		@(posedge m2) disable iff (map_rst) $onehot0(strobes)
	) else $error("cpu_reg_decode: several register strobes in one cycle");

endmodule

`default_nettype wire

//--- hw/map_037_top.sv
`timescale 1ns/1ps
`default_nettype none

module map_037_top (
	input  logic                  m2,
	input  logic                  map_rst,
	input  logic                  cfg_chr_ram,
	input  map_bus_pkg::cpu_bus_t cpu,
	input  map_bus_pkg::ppu_bus_t ppu,
	output map_bus_pkg::mem_out_t mem,
	output logic                  irq
);

	import map_reg_pkg::*;

	reg_wr_t   wr;
	map_regs_t regs;

	cpu_reg_decode u_dec (
		.m2      (m2),
		.map_rst (map_rst),
		.cpu     (cpu),
		.wr      (wr)
	);

	mmc3_bank_regs u_regs (
		.m2      (m2),
		.map_rst (map_rst),
		.wr      (wr),
		.regs    (regs)
	);

	scanline_irq u_irq (
		.m2      (m2),
		.map_rst (map_rst),
		.ppu_a12 (ppu.addr[12]),
		.wr      (wr),
		.irq     (irq)
	);

	bank_translate u_xlat (
		.cpu         (cpu),
		.ppu         (ppu),
		.m2          (m2),
		.cfg_chr_ram (cfg_chr_ram),
		.regs        (regs),
		.mem         (mem)
	);

endmodule

`default_nettype wire

//--- hw/map_bus_pkg.sv
`default_nettype none

`include "map_macros.svh"

package map_bus_pkg;

	// cpu side as seen by the cart
	typedef struct packed {
		logic [`MAP_CPU_AW-1:0] addr;
		logic [7:0]             data;
		logic                   rw;     // high = read
		logic                   romsel; // low for $8000-$ffff
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        oe;
		logic        we;
	} ppu_bus_t;

	// everything the mapper drives towards rom, ram and ciram
	typedef struct packed {
		logic [`MAP_PRG_AW-1:0]  prg_addr;
		logic                    prg_ce;
		logic                    prg_oe;
		logic                    ram_ce;
		logic                    ram_we;
		logic [`MAP_SRAM_AW-1:0] sram_addr;
		logic [`MAP_CHR_AW-1:0]  chr_addr;
		logic                    chr_ce;
		logic                    chr_oe;
		logic                    chr_we;
		logic                    ciram_a10;
		logic                    ciram_ce;
	} mem_out_t;

endpackage

`default_nettype wire

//--- hw/map_macros.svh
`ifndef MAP_MACROS_SVH
`define MAP_MACROS_SVH

// address widths
`define MAP_PRG_AW 19
`define MAP_CHR_AW 18
`define MAP_CPU_AW 15
`define MAP_SRAM_AW 13

// bank register widths and the page offsets below them
`define MAP_PRG_BW 6
`define MAP_CHR_BW 8
`define MAP_PRG_WIN 13
`define MAP_CHR_WIN 10

`define MAP_A12_HIST 5 // a12 samples kept for rise filter

`endif

//--- hw/map_reg_pkg.sv
`default_nettype none

`include "map_macros.svh"

package map_reg_pkg;

	// one write strobe per mmc3 register plus the board 37 outer select
	typedef struct packed {
		logic       bank_sel_wr;  // $8000
		logic       bank_data_wr; // $8001
		logic       mirror_wr;    // $a000
		logic       protect_wr;   // $a001
		logic       latch_wr;     // $c000
		logic       reload_wr;    // $c001
		logic       irq_off_wr;   // $e000
		logic       irq_on_wr;    // $e001
		logic       outer_wr;     // $6000-$7fff
		logic [7:0] data;
	} reg_wr_t;

	// mapping state without the irq counter
	typedef struct packed {
		logic [1:0][`MAP_PRG_BW-1:0] prg; // r6, r7
		logic [5:0][`MAP_CHR_BW-1:0] chr; // r0..r5
		logic [2:0]                  sel;
		logic                        prg_mode;
		logic                        chr_a12;
		logic                        mirror;
		logic [1:0]                  ram_protect; // [1] enable, [0] forced write
		logic [2:0]                  outer;
	} map_regs_t;

endpackage

`default_nettype wire

//--- hw/mmc3_bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_macros.svh"

module mmc3_bank_regs (
	input  logic                   m2,
	input  logic                   map_rst,
	input  map_reg_pkg::reg_wr_t   wr,
	output map_reg_pkg::map_regs_t regs
);

	always_ff @(posedge m2) begin
		if (map_rst) begin
			regs <= '0;
		end else begin
			if (wr.bank_sel_wr) begin
				regs.sel <= wr.data[2:0];
				regs.prg_mode <= wr.data[6];
				regs.chr_a12 <= wr.data[7];
			end

			if (wr.bank_data_wr) begin
				case (regs.sel)
					// 2k banks take bit 0 from ppu a10
					3'd0, 3'd1: regs.chr[regs.sel][`MAP_CHR_BW-1:1] <= wr.data[7:1];
					3'd2, 3'd3, 3'd4, 3'd5: regs.chr[regs.sel] <= wr.data;
					3'd6, 3'd7: regs.prg[regs.sel[0]] <= wr.data[`MAP_PRG_BW-1:0];
				endcase
			end

			if (wr.mirror_wr)
				regs.mirror <= wr.data[0];

			if (wr.protect_wr)
				regs.ram_protect <= wr.data[7:6];

			if (wr.outer_wr)
				regs.outer <= wr.data[2:0]; // board 37 outer select
		end
	end

	// sel may only move on a $8000 write or a reset
	a_sel_stable: assert property (
		@(posedge m2) disable iff (map_rst)
		(!$past(wr.bank_sel_wr) && !$past(map_rst)) |-> $stable(regs.sel)
	) else $error("mmc3_bank_regs: sel changed without a bank select write");

endmodule

`default_nettype wire

//--- hw/scanline_irq.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_macros.svh"

module scanline_irq (
	input  logic                 m2,
	input  logic                 map_rst,
	input  logic                 ppu_a12,
	input  map_reg_pkg::reg_wr_t wr,
	output logic                 irq
);

	logic [`MAP_A12_HIST-1:0] a12_hist; // newest sample in bit 0
	logic                     a12_rise;
	logic [7:0]               irq_latch;
	logic [7:0]               irq_count;
	logic                     irq_reload;
	logic                     irq_en;
	logic                     irq_hit;

	// a rise only counts after a run of lows
	assign a12_rise = (a12_hist == `MAP_A12_HIST'(1));

	assign irq_hit = irq_en &&
		((irq_count == 8'd1 && !irq_reload) || (irq_reload && irq_latch == 8'd0));

	always_ff @(posedge m2) begin
		if (map_rst) begin
			a12_hist <= '0;
			irq_latch <= '0;
			irq_count <= '0;
			irq_reload <= 1'b0;
			irq_en <= 1'b0;
			irq <= 1'b0;
		end else begin
			a12_hist <= {a12_hist[`MAP_A12_HIST-2:0], ppu_a12};

			if (a12_rise) begin
				if (irq_reload || irq_count == 8'd0) begin
					irq_count <= irq_latch;
					irq_reload <= 1'b0;
				end else begin
					irq_count <= irq_count - 8'd1;
				end
				if (irq_hit)
					irq <= 1'b1;
			end

			if (wr.latch_wr)
				irq_latch <= wr.data;
			if (wr.reload_wr)
				irq_reload <= 1'b1; // picked up at next counted rise

			if (wr.irq_off_wr) begin
				irq_en <= 1'b0;
				irq <= 1'b0; // ack
			end
			if (wr.irq_on_wr)
				irq_en <= 1'b1;
		end
	end

	a_irq_needs_en: assert property (
		@(posedge m2) disable iff (map_rst) $rose(irq) |-> $past(irq_en)
	) else $error("scanline_irq: irq rose while disabled");

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/map_bus_pkg.sv
hw/map_reg_pkg.sv
hw/cpu_reg_decode.sv
hw/mmc3_bank_regs.sv
hw/scanline_irq.sv
hw/bank_translate.sv
hw/map_037_top.sv
verification/map_037_checker.sv
verification/map_037_tb.sv

//--- verification/map_037_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_macros.svh"

module map_037_checker (
	input  logic                  m2,
	input  logic                  map_rst,
	input  logic                  cfg_chr_ram,
	input  map_bus_pkg::cpu_bus_t cpu,
	input  map_bus_pkg::ppu_bus_t ppu,
	input  map_bus_pkg::mem_out_t mem,
	input  logic                  irq,
	output int                    errors,
	output int                    checks
);

	logic [5:0]               r_prg [0:1]; // r6, r7
	logic [7:0]               r_chr [0:5];
	logic [2:0]               r_sel;
	logic                     r_prg_mode;
	logic                     r_chr_a12;
	logic                     r_mirror;
	logic [1:0]               r_protect;
	logic [2:0]               r_outer;
	logic [`MAP_A12_HIST-1:0] hist;
	logic [7:0]               latch;
	logic [7:0]               count;
	logic                     reload;
	logic                     irq_en;
	logic                     irq_m;
	logic                     armed;

	initial begin
		errors = 0;
		checks = 0;
		armed = 1'b0;
	end

	function automatic logic [5:0] folded_prg(input logic [5:0] b, input logic [2:0] o);
		case (o)
			3'd0, 3'd1, 3'd2: return {3'b000, b[2:0]};
			3'd3: return {3'b001, b[2:0]};
			3'd7: return {3'b100, b[2:0]};
			default: return {2'b01, b[3:0]}; // outer 4..6
		endcase
	endfunction

	task automatic clear_model();
		int i;
		for (i = 0; i < 6; i++)
			r_chr[i] = 8'd0;
		r_prg[0] = 6'd0;
		r_prg[1] = 6'd0;
		r_sel = 3'd0;
		r_prg_mode = 1'b0;
		r_chr_a12 = 1'b0;
		r_mirror = 1'b0;
		r_protect = 2'd0;
		r_outer = 3'd0;
		hist = '0;
		latch = 8'd0;
		count = 8'd0;
		reload = 1'b0;
		irq_en = 1'b0;
		irq_m = 1'b0;
	endtask

	task automatic write_bank(input logic [7:0] d);
		if (r_sel < 3'd2)
			r_chr[r_sel][7:1] = d[7:1]; // 2k banks take the low bit from ppu a10
		else if (r_sel < 3'd6)
			r_chr[r_sel] = d;
		else
			r_prg[r_sel - 3'd6] = d[5:0];
	endtask

	// state after one rising edge given the bus seen before it
	task automatic advance_model();
		logic       rise;
		logic       fire;
		logic [2:0] reg_idx;
		rise = (hist == {{(`MAP_A12_HIST-1){1'b0}}, 1'b1}); // four lows then a high
		hist = {hist[`MAP_A12_HIST-2:0], ppu.addr[12]};
		if (rise) begin
			fire = irq_en && ((count == 8'd1 && !reload) || (reload && latch == 8'd0));
			if (reload || count == 8'd0) begin
				count = latch;
				reload = 1'b0;
			end else begin
				count = count - 8'd1;
			end
			if (fire)
				irq_m = 1'b1;
		end
		if (!cpu.rw && cpu.romsel && cpu.addr[14:13] == 2'b11)
			r_outer = cpu.data[2:0];
		if (!cpu.rw && !cpu.romsel) begin
			reg_idx = {cpu.addr[14:13], cpu.addr[0]};
			case (reg_idx)
				3'd0: begin
					r_sel = cpu.data[2:0];
					r_prg_mode = cpu.data[6];
					r_chr_a12 = cpu.data[7];
				end
				3'd1: write_bank(cpu.data);
				3'd2: r_mirror = cpu.data[0];
				3'd3: r_protect = cpu.data[7:6];
				3'd4: latch = cpu.data;
				3'd5: reload = 1'b1;
				3'd6: begin
					irq_en = 1'b0;
					irq_m = 1'b0; // ack
				end
				3'd7: irq_en = 1'b1;
			endcase
		end
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t ns: %s is %0h, model expects %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic [5:0] pb;
		logic [7:0] cb;
		logic       rce;
		logic       rwe;
		case (cpu.addr[14:13])
			2'd0: pb = r_prg_mode ? 6'd62 : r_prg[0];
			2'd1: pb = r_prg[1];
			2'd2: pb = r_prg_mode ? r_prg[0] : 6'd62;
			default: pb = 6'd63;
		endcase
		pb = cpu.romsel ? 6'd0 : folded_prg(pb, r_outer);
		if (ppu.addr[12] == r_chr_a12)
			cb = {r_chr[ppu.addr[11]][7:1], ppu.addr[10]}; // 2k half
		else
			cb = r_chr[2 + ppu.addr[11:10]];
		if (r_outer >= 3'd4)
			cb[7] = 1'b1;
		rce = r_protect[1] && cpu.romsel && cpu.addr[14:13] == 2'b11 && m2;
		rwe = (rce && !cpu.rw) || r_protect[0];
		compare_value("prg_addr", mem.prg_addr, {pb, cpu.addr[12:0]});
		compare_value("prg_ce", mem.prg_ce, !cpu.romsel);
		compare_value("prg_oe", mem.prg_oe, cpu.rw);
		compare_value("sram_addr", mem.sram_addr, cpu.addr[12:0]);
		compare_value("chr_addr", mem.chr_addr, {cb, ppu.addr[9:0]});
		compare_value("chr_ce", mem.chr_ce, !ppu.addr[13]); // pattern tables below $2000
		compare_value("chr_oe", mem.chr_oe, !ppu.oe);
		compare_value("ciram_ce", mem.ciram_ce, !ppu.addr[13]); // active low ciram /ce pin
		compare_value("ram_ce", mem.ram_ce, rce);
		compare_value("ram_we", mem.ram_we, rwe);
		compare_value("chr_we", mem.chr_we, cfg_chr_ram && !ppu.we && !ppu.addr[13]);
		compare_value("ciram_a10", mem.ciram_a10, r_mirror ? ppu.addr[11] : ppu.addr[10]);
		compare_value("irq", irq, irq_m);
	endtask

	always @(posedge m2) begin
		if (map_rst) begin
			clear_model();
			armed = 1'b1;
		end else if (armed) begin
			advance_model();
		end
		#3;
		if (armed)
			check_outputs(); // m2 high
		#5;
		if (armed)
			check_outputs(); // m2 low
	end

endmodule

`default_nettype wire

//--- verification/map_037_tb.sv
`timescale 1ns/1ps
`default_nettype none

module map_037_tb;

	import map_bus_pkg::*;

	logic        m2;
	logic        map_rst;
	logic        cfg_chr_ram;
	cpu_bus_t    cpu;
	ppu_bus_t    ppu;
	mem_out_t    mem;
	logic        irq;
	int          chk_errors;
	int          chk_checks;
	int          tb_errors;
	int          errors_before;
	int          test_no;
	logic [31:0] seed;

	map_037_top dut0 (
		.m2          (m2),
		.map_rst     (map_rst),
		.cfg_chr_ram (cfg_chr_ram),
		.cpu         (cpu),
		.ppu         (ppu),
		.mem         (mem),
		.irq         (irq)
	);

	map_037_checker chk0 (
		.m2          (m2),
		.map_rst     (map_rst),
		.cfg_chr_ram (cfg_chr_ram),
		.cpu         (cpu),
		.ppu         (ppu),
		.mem         (mem),
		.irq         (irq),
		.errors      (chk_errors),
		.checks      (chk_checks)
	);

	always #5 m2 = ~m2;

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 15); // fold high bits into the weak low ones
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = next_rand();
		return r[23:16];
	endfunction

	task automatic cpu_op(input logic [15:0] a, input logic rd, input logic [7:0] d);
		@(posedge m2);
		cpu.addr <= a[14:0];
		cpu.data <= d;
		cpu.rw <= rd;
		cpu.romsel <= !a[15];
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_op(a, 1'b0, d);
	endtask

	// cpu access in [base, base+span) with a random ppu access alongside
	task automatic random_cycle(input int base, input int span, input logic may_write);
		logic [31:0] r;
		logic [31:0] p;
		r = next_rand();
		p = next_rand();
		cpu_op(16'(base + (r % span)), !(may_write && r[20]), p[31:24]);
		ppu.addr <= p[13:0];
		ppu.we <= p[17];
		ppu.oe <= !p[17];
	endtask

	task automatic a12_pulse(input int lows);
		repeat (lows) begin
			@(posedge m2);
			ppu.addr[12] <= 1'b0;
		end
		repeat (2) begin
			@(posedge m2);
			ppu.addr[12] <= 1'b1;
		end
	endtask

	task automatic wait_irq(input logic level, input int limit, output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < limit) begin
			@(negedge m2);
			if (irq === level)
				ok = 1'b1;
			n++;
		end
	endtask

	task automatic end_test(input string name);
		int now;
		@(negedge m2);
		#4; // past the checker's last compare of this cycle
		now = chk_errors + tb_errors;
		test_no++;
		$display("test %0d %s: %s, %0d errors", test_no, name,
			(now == errors_before) ? "ok" : "mismatch", now - errors_before);
		errors_before = now;
		@(posedge m2);
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  n;
		logic        ok;
		int          i;
		int          j;
		int          k;
		seed = 32'h90f7ceb2;
		m2 = 1'b0;
		map_rst = 1'b1;
		cfg_chr_ram = 1'b0;
		cpu.addr = '0;
		cpu.data = 8'h00;
		cpu.rw = 1'b1;
		cpu.romsel = 1'b1;
		ppu.addr = '0;
		ppu.oe = 1'b1;
		ppu.we = 1'b1;
		tb_errors = 0;
		errors_before = 0;
		test_no = 0;
		repeat (8) @(posedge m2);
		map_rst <= 1'b0;

		cpu_op(16'he000, 1'b1, 8'h00);
		@(negedge m2);
		// last bank 63 folded by outer 0
		if (mem.prg_addr[18:13] !== 6'd7 || irq !== 1'b0) begin
			tb_errors++;
			$display("ERR %0t ns: after reset $e000 maps to bank %0d, irq %b", $time,
				mem.prg_addr[18:13], irq);
		end
		for (j = 0; j < 60; j++)
			random_cycle(0, 32'h10000, 1'b0);
		end_test("reset state");

		for (i = 0; i < 8; i++) begin
			cpu_write(16'h8000, {1'b0, i[0], 3'b000, 3'd6});
			cpu_write(16'h8001, rand_byte());
			cpu_write(16'h8000, {1'b0, i[0], 3'b000, 3'd7});
			cpu_write(16'h8001, rand_byte());
			for (j = 0; j < 30; j++)
				random_cycle(32'h8000, 32'h8000, 1'b0);
		end
		end_test("prg modes");

		for (i = 0; i < 8; i++) begin
			cfg_chr_ram <= i[1];
			for (k = 0; k < 6; k++) begin
				cpu_write(16'h8000, {i[0], 4'b0000, k[2:0]});
				cpu_write(16'h8001, rand_byte());
			end
			for (j = 0; j < 40; j++)
				random_cycle(32'h8000, 32'h8000, 1'b0);
		end
		end_test("chr modes");

		for (i = 0; i < 8; i++) begin
			for (k = 0; k < 8; k++) begin
				cpu_write(16'h8000, {i[0], i[1], 3'b000, k[2:0]});
				cpu_write(16'h8001, rand_byte());
			end
			r = next_rand();
			cpu_write(16'h6000 | {3'b000, r[12:0]}, {r[20:16], i[2:0]});
			for (j = 0; j < 30; j++)
				random_cycle(0, 32'h10000, 1'b0);
		end
		end_test("outer folding");

		for (i = 0; i < 8; i++) begin
			cpu_write(16'ha000, {7'd0, i[0]});
			cpu_write(16'ha001, {i[2:1], 6'd0});
			for (j = 0; j < 30; j++)
				random_cycle(32'h6000, 32'h2000, 1'b1); // writes here also hit outer
		end
		end_test("mirror and wram");

		ppu.addr[12] <= 1'b0;
		for (i = 0; i < 4; i++) begin
			n = rand_byte() % 8'd6;
			if (i == 0)
				n = 8'd0;
			cpu_write(16'he000, 8'h00);
			cpu_write(16'hc000, n);
			cpu_write(16'hc001, 8'h00);
			cpu_write(16'he001, 8'h00);
			cpu_op(16'h8000, 1'b1, 8'h00);
			for (k = 0; k <= n; k++) begin
				if (k[0])
					a12_pulse(2); // too few lows to count
				a12_pulse(4);
				if (k < n) begin
					wait_irq(1'b1, 3, ok);
					if (ok) begin
						tb_errors++;
						$display("ERR %0t ns: irq rose after %0d of %0d rises", $time, k + 1,
							n + 1);
					end
				end else begin
					wait_irq(1'b1, 10, ok);
					if (!ok) begin
						tb_errors++;
						$display("timeout: irq did not rise after the last of %0d rises", n + 1);
					end
				end
			end
			cpu_write(16'he000, 8'h00);
			cpu_op(16'h8000, 1'b1, 8'h00);
			wait_irq(1'b0, 4, ok);
			if (!ok) begin
				tb_errors++;
				$display("timeout: irq still high after the acknowledge write");
			end
		end
		end_test("irq counter");

		$display("%0d tests, %0d checks, %0d errors", test_no, chk_checks,
			chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
